// File: source/cnu_config.svh
// sizes of a degree-6 check node with 4-bit messages; the RTL tree is written for exactly six edges
`ifndef CNU_CONFIG_SVH
`define CNU_CONFIG_SVH

// edges on one check node
`define CN_DEGREE 6

// width of one variable or check message
`define QUAN_SIZE 4

// magnitude bits below the sign bit
`define MAG_SIZE 3

// enough bits to number every edge
`define IDX_SIZE 3

// input sample edge to registered output
// decode, min search and encode each add one stage
`define CNU_LATENCY 3

`endif

// File: source/ldpc_msg_pkg.sv
// message types for a 4-bit min-sum decoder; sign in the top bit and magnitude stored inverted when the sign is 0
`include "cnu_config.svh"

package ldpc_msg_pkg;

	// one variable-to-check or check-to-variable message
	typedef logic [`QUAN_SIZE-1:0] chv_msg_t;

	// unsigned magnitude recovered from a message
	typedef logic [`MAG_SIZE-1:0] mag_t;

	// edge number, 0 to CN_DEGREE-1
	typedef logic [`IDX_SIZE-1:0] edge_idx_t;

	// one sign bit per edge
	typedef logic [`CN_DEGREE-1:0] sign_vec_t;

	// all messages of one check node
	// msg[i] belongs to edge i
	typedef struct packed {
		chv_msg_t [`CN_DEGREE-1:0] msg;
	} msg_bundle_t;

	// low bits <-> magnitude
	// the same mapping both ways, since it is only a conditional inversion
	function automatic mag_t msg_flip(input logic sign, input mag_t bits);
		return sign ? bits : ~bits;
	endfunction

	// sign bit of a message
	function automatic logic msg_sign(input chv_msg_t msg);
		return msg[`QUAN_SIZE-1];
	endfunction

	// magnitude of a message
	function automatic mag_t msg_mag(input chv_msg_t msg);
		return msg_flip(msg[`QUAN_SIZE-1], msg[`MAG_SIZE-1:0]);
	endfunction

endpackage

// File: source/cnu_pipe_pkg.sv
// stage-to-stage records of the check node pipeline; every field of a record belongs to the same input set
`include "cnu_config.svh"

package cnu_pipe_pkg;

	import ldpc_msg_pkg::*;

	// decode -> min finder
	// mag[i] is the magnitude on edge i
	// sign[i] is already extrinsic, the parity of the other five edges
	typedef struct packed {
		mag_t [`CN_DEGREE-1:0] mag;
		sign_vec_t             sign;
	} decoded_t;

	// min finder -> encode
	// min2 is the smallest magnitude once edge min1_idx is left out
	// equal to min1 when the minimum is shared by two or more edges
	typedef struct packed {
		mag_t      min1;
		mag_t      min2;
		edge_idx_t min1_idx;
		sign_vec_t sign;
	} min_pair_t;

endpackage

// File: source/cnu_msg_decode.sv
// stage 0 of the check node; samples v2c_i on every clock with no enable and clears to zero in reset
`timescale 1ns/1ps
`include "cnu_config.svh"

module cnu_msg_decode (
	input  logic                        sys_clk,
	input  logic                        rstn,
	input  ldpc_msg_pkg::msg_bundle_t   v2c_i,
	output cnu_pipe_pkg::decoded_t      dec_o
);

	import ldpc_msg_pkg::*;
	import cnu_pipe_pkg::*;

	sign_vec_t in_sign;
	logic      sign_parity;
	decoded_t  dec_next;

	// raw input signs
	always_comb begin
		for (int i = 0; i < `CN_DEGREE; i++) begin
			in_sign[i] = msg_sign(v2c_i.msg[i]);
		end
	end

	// product of all six signs
	assign sign_parity = ^in_sign;

	always_comb begin
		for (int i = 0; i < `CN_DEGREE; i++) begin
			dec_next.mag[i] = msg_mag(v2c_i.msg[i]);
			// removing the own sign leaves the other five
			dec_next.sign[i] = sign_parity ^ in_sign[i];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			dec_o <= '0;
		end else begin
			dec_o <= dec_next;
		end
	end

endmodule

// File: source/cnu_min_finder.sv
// stage 1 of the check node; the comparison tree is fixed to six edges and a tied minimum goes to the lowest edge
`timescale 1ns/1ps
`include "cnu_config.svh"

module cnu_min_finder (
	input  logic                     sys_clk,
	input  logic                     rstn,
	input  cnu_pipe_pkg::decoded_t   dec_i,
	output cnu_pipe_pkg::min_pair_t  mins_o
);

	import ldpc_msg_pkg::*;
	import cnu_pipe_pkg::*;

	// a magnitude together with the edge it came from
	typedef struct packed {
		mag_t      mag;
		edge_idx_t idx;
	} cand_t;

	// keeps a on a tie
	// a always carries the lower edge numbers here
	function automatic cand_t pick_min(input cand_t a, input cand_t b);
		return (b.mag < a.mag) ? b : a;
	endfunction

	// three pairs, then two levels
	function automatic cand_t tree_min(input mag_t [`CN_DEGREE-1:0] mags);
		cand_t leaf [`CN_DEGREE];
		cand_t p01;
		cand_t p23;
		cand_t p45;
		cand_t p0123;
		for (int i = 0; i < `CN_DEGREE; i++) begin
			leaf[i].mag = mags[i];
			leaf[i].idx = edge_idx_t'(i);
		end
		p01   = pick_min(leaf[0], leaf[1]);
		p23   = pick_min(leaf[2], leaf[3]);
		p45   = pick_min(leaf[4], leaf[5]);
		p0123 = pick_min(p01, p23);
		return pick_min(p0123, p45);
	endfunction

	cand_t                 first;
	cand_t                 second;
	mag_t [`CN_DEGREE-1:0] masked;
	min_pair_t             mins_next;

	assign first = tree_min(dec_i.mag);

	// hide the winning edge behind the largest magnitude
	// a shared minimum still shows up on another edge
	always_comb begin
		for (int i = 0; i < `CN_DEGREE; i++) begin
			if (edge_idx_t'(i) == first.idx) begin
				masked[i] = {`MAG_SIZE{1'b1}};
			end else begin
				masked[i] = dec_i.mag[i];
			end
		end
	end

	assign second = tree_min(masked);

	always_comb begin
		mins_next.min1     = first.mag;
		mins_next.min2     = second.mag;
		mins_next.min1_idx = first.idx;
		// signs ride along with the magnitudes they came with
		mins_next.sign     = dec_i.sign;
	end

	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			mins_o <= '0;
		end else begin
			mins_o <= mins_next;
		end
	end

endmodule

// File: source/cnu_msg_encode.sv
// stage 2 of the check node; outputs use the input encoding and read zero until the first set arrives
`timescale 1ns/1ps
`include "cnu_config.svh"

module cnu_msg_encode (
	input  logic                       sys_clk,
	input  logic                       rstn,
	input  cnu_pipe_pkg::min_pair_t    mins_i,
	output ldpc_msg_pkg::msg_bundle_t  c2v_o
);

	import ldpc_msg_pkg::*;

	mag_t [`CN_DEGREE-1:0] sel_mag;
	msg_bundle_t           c2v_next;

	// the edge that owns the minimum gets the runner-up
	always_comb begin
		for (int i = 0; i < `CN_DEGREE; i++) begin
			if (edge_idx_t'(i) == mins_i.min1_idx) begin
				sel_mag[i] = mins_i.min2;
			end else begin
				sel_mag[i] = mins_i.min1;
			end
		end
	end

	// back to sign plus conditionally inverted magnitude
	always_comb begin
		for (int i = 0; i < `CN_DEGREE; i++) begin
			c2v_next.msg[i] = {mins_i.sign[i], msg_flip(mins_i.sign[i], sel_mag[i])};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			c2v_o <= '0;
		end else begin
			c2v_o <= c2v_next;
		end
	end

endmodule

// File: source/cnu_top.sv
// min-sum check node for six 4-bit edges; fixed 3-cycle latency, one input set per clock, no handshake
`timescale 1ns/1ps

module cnu_top (
	input  logic                       sys_clk,
	input  logic                       rstn,
	input  ldpc_msg_pkg::msg_bundle_t  v2c_i,
	output ldpc_msg_pkg::msg_bundle_t  c2v_o
);

	import cnu_pipe_pkg::*;

	decoded_t  dec;
	min_pair_t mins;

	// sampled at edge k
	cnu_msg_decode i_cnu_msg_decode (
		.sys_clk (sys_clk),
		.rstn    (rstn),
		.v2c_i   (v2c_i),
		.dec_o   (dec)
	);

	// edge k+1
	cnu_min_finder i_cnu_min_finder (
		.sys_clk (sys_clk),
		.rstn    (rstn),
		.dec_i   (dec),
		.mins_o  (mins)
	);

	// edge k+2, result visible on c2v_o after it
	cnu_msg_encode i_cnu_msg_encode (
		.sys_clk (sys_clk),
		.rstn    (rstn),
		.mins_i  (mins),
		.c2v_o   (c2v_o)
	);

endmodule

// File: tb/cnu_asserts.sv
// port-level checks on cnu_top; assumes rstn is low at the first clock edge
`timescale 1ns/1ps
`include "cnu_config.svh"

module cnu_asserts (
	input logic                       sys_clk,
	input logic                       rstn,
	input ldpc_msg_pkg::msg_bundle_t  v2c_i,
	input ldpc_msg_pkg::msg_bundle_t  c2v_o
);

	import ldpc_msg_pkg::*;

	logic seen_reset = 1'b0;
	int   fail_count = 0;
	logic in_parity;
	logic out_parity;
	logic idle_now;

	always @(posedge sys_clk) begin
		if (!rstn) begin
			seen_reset <= 1'b1;
		end
	end

	always_comb begin
		in_parity  = 1'b0;
		out_parity = 1'b0;
		idle_now   = 1'b1;
		for (int i = 0; i < `CN_DEGREE; i++) begin
			in_parity  ^= v2c_i.msg[i][`QUAN_SIZE-1];
			out_parity ^= c2v_o.msg[i][`QUAN_SIZE-1];
			// magnitude 0 with positive sign
			if (c2v_o.msg[i] != {1'b0, {`MAG_SIZE{1'b1}}}) begin
				idle_now = 1'b0;
			end
		end
	end

	reset_clears: assert property (@(posedge sys_clk)
		seen_reset && !$past(rstn) |-> c2v_o == '0)
		else begin
			fail_count++;
			$error("c2v_o not cleared after a reset edge");
		end

	// the first two results after release come from cleared stages
	release_idle: assert property (@(posedge sys_clk)
		seen_reset && $past(rstn) && (!$past(rstn, 2) || !$past(rstn, 3)) |-> idle_now)
		else begin
			fail_count++;
			$error("c2v_o not at the cleared-pipeline value after reset release");
		end

	// six extrinsic signs xor back to the input parity
	sign_parity: assert property (@(posedge sys_clk)
		seen_reset && $past(rstn) && $past(rstn, 2) && $past(rstn, 3)
		|-> out_parity == $past(in_parity, 3))
		else begin
			fail_count++;
			$error("output sign parity differs from input parity three cycles earlier");
		end

endmodule

bind cnu_top cnu_asserts i_cnu_asserts (
	.sys_clk (sys_clk),
	.rstn    (rstn),
	.v2c_i   (v2c_i),
	.c2v_o   (c2v_o)
);

// File: tb/cnu_checker.sv
// min-sum reference for the check node; assumes inputs change only on the falling edge and a 3-edge latency
`timescale 1ns/1ps
`include "cnu_config.svh"

module cnu_checker (
	input  logic                       sys_clk,
	input  logic                       rstn,
	input  ldpc_msg_pkg::msg_bundle_t  v2c_i,
	input  ldpc_msg_pkg::msg_bundle_t  c2v_i,
	input  logic [2:0]                 phase_i,
	output int                         checks_o,
	output int                         errors_o,
	output int                         tests_o
);

	import ldpc_msg_pkg::*;

	typedef struct packed {
		msg_bundle_t msgs;
		logic [2:0]  tag;
	} pred_t;

	pred_t      pred_q[$];
	pred_t      exp_cur;
	logic       exp_valid    = 1'b0;
	logic [2:0] last_tag     = 3'd0;
	int         since_reset  = 0;
	int         n_checks     = 0;
	int         n_errors     = 0;
	int         n_tests      = 0;
	int         phase_checks = 0;
	int         phase_errors = 0;

	assign checks_o = n_checks;
	assign errors_o = n_errors;
	assign tests_o  = n_tests;

	function automatic mag_t mag_of(input chv_msg_t m);
		if (m[`QUAN_SIZE-1]) begin
			return m[`MAG_SIZE-1:0];
		end
		return ~m[`MAG_SIZE-1:0];
	endfunction

	function automatic chv_msg_t pack_msg(input logic sign, input mag_t mag);
		return sign ? {1'b1, mag} : {1'b0, ~mag};
	endfunction

	// each edge sees only the other five
	function automatic msg_bundle_t expect_c2v(input msg_bundle_t v2c);
		msg_bundle_t r;
		logic        sign;
		mag_t        best;
		for (int e = 0; e < `CN_DEGREE; e++) begin
			sign = 1'b0;
			best = '1;
			for (int j = 0; j < `CN_DEGREE; j++) begin
				if (j != e) begin
					sign ^= v2c.msg[j][`QUAN_SIZE-1];
					if (mag_of(v2c.msg[j]) < best) begin
						best = mag_of(v2c.msg[j]);
					end
				end
			end
			r.msg[e] = pack_msg(sign, best);
		end
		return r;
	endfunction

	// a cleared min stage reads as magnitude 0, positive
	function automatic msg_bundle_t idle_c2v();
		msg_bundle_t r;
		for (int e = 0; e < `CN_DEGREE; e++) begin
			r.msg[e] = pack_msg(1'b0, '0);
		end
		return r;
	endfunction

	function automatic string phase_name(input logic [2:0] tag);
		case (tag)
			3'd1: return "reset";
			3'd2: return "sign";
			3'd3: return "min_select";
			3'd4: return "ties";
			3'd5: return "throughput";
			default: return "drain";
		endcase
	endfunction

	task automatic close_phase(input logic [2:0] tag);
		n_tests++;
		if (phase_errors == 0) begin
			$display("test %-10s passed, %0d checks", phase_name(tag), phase_checks);
		end else begin
			$display("test %-10s failed, %0d of %0d checks wrong",
				phase_name(tag), phase_errors, phase_checks);
		end
		phase_checks = 0;
		phase_errors = 0;
	endtask

	task automatic compare_bundle(input pred_t want, input msg_bundle_t got);
		for (int e = 0; e < `CN_DEGREE; e++) begin
			n_checks++;
			phase_checks++;
			if (got.msg[e] !== want.msgs.msg[e]) begin
				n_errors++;
				phase_errors++;
				$display("CHECK FAILED at %0t: %s edge %0d expected %h (sign %b mag %0d) got %h",
					$time, phase_name(want.tag), e, want.msgs.msg[e],
					want.msgs.msg[e][`QUAN_SIZE-1], mag_of(want.msgs.msg[e]), got.msg[e]);
			end
		end
	endtask

	always @(posedge sys_clk) begin
		pred_t fresh;
		// c2v_i still holds the value from the previous edge here
		if (exp_valid) begin
			if (exp_cur.tag != last_tag) begin
				if (last_tag != 3'd0) begin
					close_phase(last_tag);
				end
				last_tag = exp_cur.tag;
			end
			compare_bundle(exp_cur, c2v_i);
		end
		fresh.msgs = expect_c2v(v2c_i);
		fresh.tag  = phase_i;
		pred_q.push_back(fresh);
		if (pred_q.size() > `CNU_LATENCY) begin
			void'(pred_q.pop_front());
		end
		// expected output after this edge
		if (!rstn) begin
			since_reset  = 0;
			exp_cur.msgs = '0;
			exp_cur.tag  = phase_i;
		end else begin
			since_reset++;
			exp_cur.tag = pred_q[0].tag;
			if (since_reset < `CNU_LATENCY) begin
				exp_cur.msgs = idle_c2v();
			end else begin
				exp_cur.msgs = pred_q[0].msgs;
			end
		end
		exp_valid = 1'b1;
	end

endmodule

// File: tb/tb_cnu_top.sv
// seeded random stimulus for the check node; needs bind support, since it reads the assertion failure count
`timescale 1ns/1ps
`include "cnu_config.svh"

module tb_cnu_top;

	import ldpc_msg_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int SIGN_LEN     = 60;
	localparam int MIN_LEN      = 60;
	localparam int TIE_LEN      = 60;
	localparam int STREAM_LEN   = 200;
	localparam int DRAIN_LEN    = `CNU_LATENCY + 2;
	localparam int MARGIN       = 20;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + SIGN_LEN + MIN_LEN + TIE_LEN + STREAM_LEN
		+ DRAIN_LEN + `CNU_LATENCY + MARGIN;
	localparam int NUM_TESTS    = 5;

	logic        sys_clk;
	logic        rstn;
	msg_bundle_t v2c;
	msg_bundle_t c2v;
	logic [2:0]  phase;
	int          checks;
	int          errors;
	int          tests;
	int          cycles = 0;

	cnu_top i_cnu_top (
		.sys_clk (sys_clk),
		.rstn    (rstn),
		.v2c_i   (v2c),
		.c2v_o   (c2v)
	);

	cnu_checker i_cnu_checker (
		.sys_clk  (sys_clk),
		.rstn     (rstn),
		.v2c_i    (v2c),
		.c2v_i    (c2v),
		.phase_i  (phase),
		.checks_o (checks),
		.errors_o (errors),
		.tests_o  (tests)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// sign in the top bit, magnitude inverted for a positive message
	function automatic chv_msg_t build_msg(input logic sign, input mag_t mag);
		return sign ? {1'b1, mag} : {1'b0, ~mag};
	endfunction

	function automatic logic rand_bit();
		return logic'($urandom_range(1, 0));
	endfunction

	function automatic msg_bundle_t rand_bundle();
		msg_bundle_t b;
		for (int e = 0; e < `CN_DEGREE; e++) begin
			b.msg[e] = chv_msg_t'($urandom_range(15, 0));
		end
		return b;
	endfunction

	// one edge strictly below all others
	function automatic msg_bundle_t unique_min_bundle();
		msg_bundle_t b;
		int          low_edge;
		int          low_mag;
		low_edge = int'($urandom_range(`CN_DEGREE - 1, 0));
		low_mag  = int'($urandom_range(6, 0));
		for (int e = 0; e < `CN_DEGREE; e++) begin
			if (e == low_edge) begin
				b.msg[e] = build_msg(rand_bit(), mag_t'(low_mag));
			end else begin
				b.msg[e] = build_msg(rand_bit(), mag_t'($urandom_range(7, low_mag + 1)));
			end
		end
		return b;
	endfunction

	// at least two edges share the smallest magnitude
	function automatic msg_bundle_t tied_min_bundle();
		msg_bundle_t b;
		int          edge_a;
		int          edge_b;
		int          low_mag;
		low_mag = int'($urandom_range(7, 0));
		edge_a  = int'($urandom_range(`CN_DEGREE - 1, 0));
		edge_b  = (edge_a + int'($urandom_range(`CN_DEGREE - 1, 1))) % `CN_DEGREE;
		for (int e = 0; e < `CN_DEGREE; e++) begin
			if (e == edge_a || e == edge_b) begin
				b.msg[e] = build_msg(rand_bit(), mag_t'(low_mag));
			end else begin
				b.msg[e] = build_msg(rand_bit(), mag_t'($urandom_range(7, low_mag)));
			end
		end
		return b;
	endfunction

	task automatic drive_phase(input logic [2:0] tag, input int len);
		repeat (len) begin
			@(negedge sys_clk);
			phase = tag;
			case (tag)
				3'd3: v2c = unique_min_bundle();
				3'd4: v2c = tied_min_bundle();
				default: v2c = rand_bundle();
			endcase
		end
	endtask

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		int seed_ret;
		int assert_fails;
		rstn  = 1'b0;
		v2c   = '0;
		phase = 3'd1;
		seed_ret = $urandom(22588);
		repeat (RESET_CYCLES) @(negedge sys_clk);
		rstn = 1'b1;
		drive_phase(3'd2, SIGN_LEN);
		drive_phase(3'd3, MIN_LEN);
		drive_phase(3'd4, TIE_LEN);
		drive_phase(3'd5, STREAM_LEN);
		// keeps the pipeline moving so the last test gets compared
		drive_phase(3'd0, DRAIN_LEN);
		assert_fails = i_cnu_top.i_cnu_asserts.fail_count;
		$display("summary: %0d of %0d tests reported, %0d checks, %0d errors, %0d assertion failures",
			tests, NUM_TESTS, checks, errors, assert_fails);
		if (errors == 0 && tests == NUM_TESTS && assert_fails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+source
source/ldpc_msg_pkg.sv
source/cnu_pipe_pkg.sv
source/cnu_msg_decode.sv
source/cnu_min_finder.sv
source/cnu_msg_encode.sv
source/cnu_top.sv
tb/cnu_asserts.sv
tb/cnu_checker.sv
tb/tb_cnu_top.sv
